/* verilog.f */
+incdir+common
common/deflate_pkg.sv
src/sync_fifo.sv
src/crc32_update.sv
src/bit_packer.sv
stored_block/stored_block_ctrl.sv
src/deflate_stored_top.sv
sim/tb_deflate_stored.sv

/* Makefile */
TOP := tb_deflate_stored

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP) \
		-f verilog.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir

/* sim/tb_deflate_stored.sv */
// Directed tests with one gzip stream per reset and a cycle limit on every stream wait
`timescale 1ns/10ps
`include "deflate_defs.svh"

module tb_deflate_stored;

	localparam logic [31:0] crc_poly     = 32'hEDB8_8320; // Reflected gzip polynomial
	localparam int          stream_limit = 4000;          // Cycles allowed for one stream

	logic        clk;
	logic        rst_n;
	logic        in_push;
	logic [31:0] in_data;
	logic        out_pop;
	logic        byte_swap;
	logic        in_full;
	logic [31:0] out_data;
	logic        out_last;
	logic        out_empty;
	logic        done;

	integer      seed;
	int          checks     = 0;
	int          mismatches = 0;
	int          failures   = 0;   // Timeouts and other non-value failures
	bit          swap_mode;        // Words cross the bus byte-reversed
	bit          full_seen;        // Input FIFO reported full during the last stream
	logic [31:0] isize;            // Model ISIZE over all blocks of the stream
	logic [31:0] push_words[$];    // Words still to be written, in model byte order
	logic [7:0]  data_bytes[$];    // Every data byte of the stream, for the model CRC
	logic [7:0]  exp_bytes[$];     // Expected output byte stream
	logic [31:0] rcv_words[$];
	bit          rcv_last[$];

	deflate_stored_top dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_push   (in_push),
		.in_data   (in_data),
		.out_pop   (out_pop),
		.byte_swap (byte_swap),
		.in_full   (in_full),
		.out_data  (out_data),
		.out_last  (out_last),
		.out_empty (out_empty),
		.done      (done)
	);

	always #50 clk = ~clk; // 100 ns period

	// ==========================================================================
	// Reference model
	// ==========================================================================

	function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Bit at a time over all data bytes with the LSB of each byte first
	function automatic logic [31:0] reference_crc32();
		logic [31:0] crc;
		crc = 32'hFFFF_FFFF;
		foreach (data_bytes[i])
			for (int k = 0; k < 8; k++)
				if (crc[0] ^ data_bytes[i][k])
					crc = (crc >> 1) ^ crc_poly;
				else
					crc = crc >> 1;
		return ~crc;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		checks++;
		if (got !== expected) begin
			mismatches++;
			$display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, expected);
		end
	endtask

	// Adds one block to the input words and its framing and data to the expected bytes
	task automatic add_block(input int len, input bit bfinal);
		logic [31:0] word;
		logic [31:0] crc;
		int          r;
		word = '0;
		word[`HDR_BFINAL_BIT] = bfinal;
		word[15:0] = len[15:0];
		push_words.push_back(word);
		exp_bytes.push_back({7'b0, bfinal});  // BTYPE 00 and pad are zero
		exp_bytes.push_back(len[7:0]);
		exp_bytes.push_back(len[15:8]);
		exp_bytes.push_back(~len[7:0]);       // NLEN
		exp_bytes.push_back(~len[15:8]);
		isize = isize + len;
		for (int i = 0; i < len; i++) begin
			if (i % 4 == 0)
				word = $random(seed);         // Unused lanes of the last word stay random
			r = $random(seed);
			word[8*(i%4) +: 8] = r[7:0];
			data_bytes.push_back(r[7:0]);
			exp_bytes.push_back(r[7:0]);
			if ((i % 4 == 3) || (i == len - 1))
				push_words.push_back(word);
		end
		if (bfinal) begin
			crc = reference_crc32();
			for (int k = 0; k < 4; k++)
				exp_bytes.push_back(crc[8*k +: 8]);
			for (int k = 0; k < 4; k++)
				exp_bytes.push_back(isize[8*k +: 8]);
		end
	endtask

	// ==========================================================================
	// Stimulus and drain
	// ==========================================================================

	task automatic start_test(input bit swap);
		@(posedge clk);
		rst_n     <= 1'b0;
		in_push   <= 1'b0;
		out_pop   <= 1'b0;
		byte_swap <= swap;
		swap_mode = swap;
		isize     = '0;
		push_words.delete();
		data_bytes.delete();
		exp_bytes.delete();
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	// Pushes and pops at most every other cycle so each flag read already shows the last move
	task automatic run_stream(input bit hold_pop);
		int          cycles;
		bit          got_last;
		bit          pop_ok;
		bit          push_now;
		bit          pop_now;
		logic [31:0] next_word;
		cycles    = 0;
		got_last  = 1'b0;
		pop_ok    = !hold_pop;  // Draining waits for a full input FIFO when held
		next_word = '0;
		full_seen = 1'b0;
		rcv_words.delete();
		rcv_last.delete();
		while (!got_last && (cycles < stream_limit)) begin
			@(negedge clk);
			cycles++;
			push_now = 1'b0;
			pop_now  = 1'b0;
			if (in_full) begin
				full_seen = 1'b1;
				pop_ok    = 1'b1;
			end
			if (!in_push && !in_full && (push_words.size() > 0)) begin
				push_now  = 1'b1;
				next_word = push_words.pop_front();
			end
			if (pop_ok && !out_pop && !out_empty) begin
				rcv_words.push_back(out_data);
				rcv_last.push_back(out_last);
				got_last = out_last;
				pop_now  = 1'b1;
			end
			@(posedge clk);
			in_push <= push_now;
			in_data <= swap_mode ? reverse_bytes(next_word) : next_word;
			out_pop <= pop_now;
		end
		@(posedge clk);
		in_push <= 1'b0;
		out_pop <= 1'b0;
		if (!got_last) begin
			failures++;
			$display("timeout at %0t: no last output word within %0d cycles", $time,
				stream_limit);
		end
	endtask

	task automatic compare_stream(input string name);
		logic [31:0] w;
		int          n_words;
		n_words = (exp_bytes.size() + 3) / 4;
		check_value(32'(rcv_words.size()), 32'(n_words), {name, " word count"});
		for (int i = 0; (i < n_words) && (i < rcv_words.size()); i++) begin
			w = '0;                                  // Last word is zero filled
			for (int k = 0; k < 4; k++)
				if (4*i + k < exp_bytes.size())
					w[8*k +: 8] = exp_bytes[4*i + k];
			if (swap_mode)
				w = reverse_bytes(w);
			check_value(rcv_words[i], w, $sformatf("%s word %0d", name, i));
			check_value(32'(rcv_last[i]), 32'(i == n_words - 1),
				$sformatf("%s last flag of word %0d", name, i));
		end
		@(negedge clk);
		check_value(32'(out_empty), 32'd1, {name, " output empty after last word"});
	endtask

	// ==========================================================================
	// Directed tests
	// ==========================================================================

	task automatic verify_crc_model();
		data_bytes.delete();
		for (int i = 0; i < 9; i++)
			data_bytes.push_back(8'h31 + 8'(i)); // ASCII 123456789
		check_value(reference_crc32(), 32'hCBF4_3926, "model CRC32 check value");
		data_bytes.delete();
		check_value(reference_crc32(), 32'h0000_0000, "model CRC32 of no bytes");
	endtask

	task automatic single_final_block();
		start_test(1'b0);
		add_block(5, 1'b1);
		run_stream(1'b0);
		compare_stream("single block");
	endtask

	task automatic three_block_stream();
		start_test(1'b0);
		add_block(7, 1'b0);
		add_block(4, 1'b0);
		add_block(9, 1'b1);  // CRC and ISIZE cover all 20 bytes
		run_stream(1'b0);
		compare_stream("three blocks");
	endtask

	task automatic empty_final_block();
		start_test(1'b0);
		add_block(0, 1'b1);
		run_stream(1'b0);
		compare_stream("empty block");
		if (rcv_words.size() >= 2) begin
			check_value(rcv_words[0], 32'hFF00_0001, "empty block header and LEN");
			check_value(rcv_words[1], 32'h0000_00FF, "empty block NLEN high byte");
		end
	endtask

	task automatic swapped_byte_order();
		start_test(1'b1);
		add_block(6, 1'b0);
		add_block(11, 1'b1);
		run_stream(1'b0);
		compare_stream("byte swap");
	endtask

	// Output is left undrained until the input FIFO fills up behind the stalled controller
	task automatic output_back_pressure();
		start_test(1'b0);
		for (int b = 0; b < 4; b++)
			add_block(60, b == 3);
		run_stream(1'b1);
		if (!full_seen) begin
			failures++;
			$display("back-pressure test: input FIFO never reported full");
		end
		compare_stream("back-pressure");
	endtask

	task automatic done_after_drain();
		start_test(1'b0);
		@(negedge clk);
		check_value(32'(done), 32'd0, "done after reset");
		check_value(32'(out_empty), 32'd1, "output empty after reset");
		check_value(32'(out_last), 32'd0, "out_last after reset");
		add_block(3, 1'b1);
		run_stream(1'b0);
		compare_stream("done flag");
		check_value(32'(done), 32'd1, "done after drain");
		repeat (16) begin
			@(negedge clk);
			check_value(32'(done), 32'd1, "done holds");
		end
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		clk       = 1'b0;
		rst_n     <= 1'b0;
		in_push   <= 1'b0;
		in_data   <= '0;
		out_pop   <= 1'b0;
		byte_swap <= 1'b0;
		seed      = 32'h8037d855;
		verify_crc_model();
		single_final_block();
		three_block_stream();
		empty_final_block();
		swapped_byte_order();
		output_back_pressure();
		done_after_drain();
		$display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
		if ((mismatches == 0) && (failures == 0))
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* src/deflate_stored_top.sv */
// One gzip member body per reset, and byte_swap should stay stable for the whole stream
`timescale 1ns/10ps
`include "deflate_defs.svh"

module deflate_stored_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_push,
	input  deflate_pkg::word_t  in_data,
	input  logic                out_pop,
	input  logic                byte_swap,  // Reverses bytes of input and output words
	output logic                in_full,
	output deflate_pkg::word_t  out_data,
	output logic                out_last,
	output logic                out_empty,
	output logic                done
);

	import deflate_pkg::*;

	word_t                        in_data_sw;
	word_t                        in_word;
	logic                         in_empty;
	logic                         in_fifo_pop;
	logic                         field_valid;
	bit_count_t                   field_size;
	word_t                        field_data;
	logic                         field_last;
	logic                         crc_valid;
	byte_t                        crc_byte;
	crc_t                         crc_value;
	logic                         out_push;
	word_t                        out_word;
	logic                         out_word_last;
	logic                         out_full;
	logic [`OUT_FIFO_DEPTH_LOG:0] out_level;
	word_t                        out_word_raw;

	// ======================================================================
	// Input side
	// ======================================================================

	assign in_data_sw = byte_swap ?
		{in_data[7:0], in_data[15:8], in_data[23:16], in_data[31:24]} : in_data;

	sync_fifo #(.width(`DEFLATE_WORD_W), .depth_log(`IN_FIFO_DEPTH_LOG)) in_fifo_i0 (
		.clk   (clk),
		.rst_n (rst_n),
		.push  (in_push),
		.din   (in_data_sw),
		.pop   (in_fifo_pop),
		.dout  (in_word),
		.full  (in_full),
		.empty (in_empty),
		.level ()          // Controller only watches the output occupancy
	);

	stored_block_ctrl ctrl_i0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_word     (in_word),
		.in_empty    (in_empty),
		.out_level   (out_level),
		.crc_value   (crc_value),
		.in_fifo_pop (in_fifo_pop),
		.field_valid (field_valid),
		.field_size  (field_size),
		.field_data  (field_data),
		.field_last  (field_last),
		.crc_valid   (crc_valid),
		.crc_byte    (crc_byte),
		.done        (done)
	);

	crc32_update crc_i0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.crc_valid (crc_valid),
		.crc_byte  (crc_byte),
		.crc_value (crc_value)
	);

	// ======================================================================
	// Output side with the last flag as the top bit of each entry
	// ======================================================================

	bit_packer packer_i0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.field_valid   (field_valid),
		.field_size    (field_size),
		.field_data    (field_data),
		.field_last    (field_last),
		.out_full      (out_full),
		.out_push      (out_push),
		.out_word      (out_word),
		.out_word_last (out_word_last)
	);

	sync_fifo #(.width(`DEFLATE_WORD_W + 1), .depth_log(`OUT_FIFO_DEPTH_LOG)) out_fifo_i0 (
		.clk   (clk),
		.rst_n (rst_n),
		.push  (out_push),
		.din   ({out_word_last, out_word}),
		.pop   (out_pop),
		.dout  ({out_last, out_word_raw}),
		.full  (out_full),
		.empty (out_empty),
		.level (out_level)
	);

	assign out_data = byte_swap ?
		{out_word_raw[7:0], out_word_raw[15:8], out_word_raw[23:16], out_word_raw[31:24]} :
		out_word_raw;

endmodule

/* stored_block/stored_block_ctrl.sv */
// Stored blocks only where each block begins on a header word and LEN above 65535 cannot be expressed
`timescale 1ns/10ps
`include "deflate_defs.svh"

module stored_block_ctrl (
	input  logic                         clk,
	input  logic                         rst_n,
	input  deflate_pkg::word_t           in_word,    // Head of the input FIFO
	input  logic                         in_empty,
	input  logic [`OUT_FIFO_DEPTH_LOG:0] out_level,  // Output FIFO occupancy
	input  deflate_pkg::crc_t            crc_value,
	output logic                         in_fifo_pop,
	output logic                         field_valid,
	output deflate_pkg::bit_count_t      field_size,
	output deflate_pkg::word_t           field_data,
	output logic                         field_last,
	output logic                         crc_valid,
	output deflate_pkg::byte_t           crc_byte,
	output logic                         done
);

	import deflate_pkg::*;

	localparam logic [`OUT_FIFO_DEPTH_LOG:0] af_level =
		(`OUT_FIFO_DEPTH_LOG + 1)'(`OUT_ALMOST_FULL_LEVEL);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	word_t       word_q;      // Data word being split into bytes
	logic [1:0]  byte_idx;    // Byte lane of word_q counted from the lowest byte
	block_len_t  bytes_left;  // Data bytes still owed by this block where zero means header next
	logic        bfinal_q;
	word_t       isize_q;     // Sum of LEN values, wraps at 2^32
	logic        can_start;
	logic        hdr_pop;
	byte_t       cur_byte;

	// A new word is only taken while the output side has room for its fields
	assign can_start = !in_empty && (out_level < af_level);
	assign hdr_pop   = in_fifo_pop && (state == st_idle) && (bytes_left == '0);
	assign cur_byte  = word_q[8*byte_idx +: 8];
	assign crc_byte  = cur_byte; // CRC sees exactly the bytes sent as data fields
	assign done      = (state == st_done);

	// ======================================================================
	// Next state and field issue
	// ======================================================================

	always_comb begin
		state_nxt   = state;
		in_fifo_pop = 1'b0;
		field_valid = 1'b0;
		field_size  = '0;
		field_data  = '0;
		field_last  = 1'b0;
		crc_valid   = 1'b0;
		case (state)
			st_idle: begin
				if (can_start) begin
					in_fifo_pop = 1'b1;
					// With no bytes owed the head word is a block header
					state_nxt = (bytes_left == '0) ? st_block_header : st_load_byte;
				end
			end
			st_block_header: begin
				field_valid = 1'b1;       // BTYPE 00 and pad bits are zero
				field_size  = 6'd8;
				field_data  = word_t'(bfinal_q);
				state_nxt   = st_block_len;
			end
			st_block_len: begin
				field_valid = 1'b1;
				field_size  = 6'd32;
				field_data  = {~bytes_left, bytes_left}; // LEN low half then NLEN
				if (bytes_left == '0)
					state_nxt = st_end_of_block;
				else if (can_start) begin
					in_fifo_pop = 1'b1;
					state_nxt   = st_load_byte;
				end else
					state_nxt = st_idle;
			end
			st_load_byte: begin
				field_valid = 1'b1;
				field_size  = 6'd8;
				field_data  = word_t'(cur_byte);
				crc_valid   = 1'b1;
				if (bytes_left == 16'd1)
					state_nxt = st_end_of_block; // Leftover lanes of the word are dropped
				else if (byte_idx == 2'd3) begin
					if (can_start)
						in_fifo_pop = 1'b1;      // Next word follows without a gap
					else
						state_nxt = st_idle;
				end
			end
			st_end_of_block: state_nxt = bfinal_q ? st_crc32 : st_idle;
			st_crc32: begin
				field_valid = 1'b1;
				field_size  = 6'd32;
				field_data  = crc_value;
				state_nxt   = st_isize;
			end
			st_isize: begin
				field_valid = 1'b1;
				field_size  = 6'd32;
				field_data  = isize_q;
				field_last  = 1'b1;  // Packer flushes the partial word behind this
				state_nxt   = st_done;
			end
			st_done:  state_nxt = st_done;
			default:  state_nxt = st_idle;
		endcase
	end

	// ======================================================================
	// State, counters and header latch
	// ======================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= st_idle;
			bytes_left <= '0;
			byte_idx   <= '0;
			bfinal_q   <= 1'b0;
			isize_q    <= '0;
		end else begin
			state <= state_nxt;
			if (hdr_pop) begin
				bfinal_q   <= in_word[`HDR_BFINAL_BIT];
				bytes_left <= in_word[15:0];
				isize_q    <= isize_q + word_t'(in_word[15:0]);
			end else if (state == st_load_byte)
				bytes_left <= bytes_left - 1'b1;
			if (in_fifo_pop)
				byte_idx <= '0; // Every word starts at its lowest byte
			else if (state == st_load_byte)
				byte_idx <= byte_idx + 1'b1;
		end
	end

	// Popped word held for its byte cycles
	always_ff @(posedge clk) begin
		if (in_fifo_pop)
			word_q <= in_word;
	end

endmodule

/* src/bit_packer.sv */
// Packs 1 to 32 bit fields LSB first and takes no field after a last one until the flush ends
`timescale 1ns/10ps
`include "deflate_defs.svh"

module bit_packer (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     field_valid,
	input  deflate_pkg::bit_count_t  field_size,
	input  deflate_pkg::word_t       field_data,
	input  logic                     field_last,
	input  logic                     out_full,
	output logic                     out_push,
	output deflate_pkg::word_t       out_word,
	output logic                     out_word_last
);

	import deflate_pkg::*;

	localparam logic [6:0] word_bits = 7'(`DEFLATE_WORD_W);

	logic [63:0] acc;            // Held bits with zeros above bit_cnt
	logic [6:0]  bit_cnt;        // Valid bits in acc and never above 31 between fields
	logic        flush_pending;  // Residue of a last field still to go out
	logic [63:0] field_ext;
	logic [63:0] merged;
	logic [6:0]  next_cnt;

	// ======================================================================
	// Append the new field above the bits already held
	// ======================================================================

	always_comb begin
		field_ext = {32'b0, field_data} & ((64'h1 << field_size) - 64'h1); // Drop bits above size
		merged    = acc | (field_ext << bit_cnt);
		next_cnt  = bit_cnt + {1'b0, field_size};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc           <= '0;
			bit_cnt       <= '0;
			flush_pending <= 1'b0;
			out_push      <= 1'b0;
			out_word_last <= 1'b0;
		end else begin
			out_push      <= 1'b0;
			out_word_last <= 1'b0;
			if (flush_pending) begin
				// Second word of a closing field is zero filled above the residue
				out_push      <= 1'b1;
				out_word_last <= 1'b1;
				acc           <= '0;
				bit_cnt       <= '0;
				flush_pending <= 1'b0;
			end else if (field_valid) begin
				if (field_last && (next_cnt <= word_bits)) begin
					out_push      <= 1'b1; // Whole remainder fits in one word
					out_word_last <= 1'b1;
					acc           <= '0;
					bit_cnt       <= '0;
				end else if (next_cnt >= word_bits) begin
					out_push      <= 1'b1;
					acc           <= merged >> word_bits;
					bit_cnt       <= next_cnt - word_bits;
					flush_pending <= field_last; // Residue follows next cycle
				end else begin
					acc     <= merged;
					bit_cnt <= next_cnt;
				end
			end
		end
	end

	// Word payload follows the field or flush that fills it
	always_ff @(posedge clk) begin
		if (flush_pending)
			out_word <= acc[31:0];
		else if (field_valid)
			out_word <= merged[31:0];
	end

	// No stall input here, so the controller must leave room in the output FIFO
	assert property (@(posedge clk) disable iff (!rst_n) out_push |-> !out_full)
		else $error("packer pushed into full output FIFO");
	// Controller stays quiet while the residue of the last field drains
	assert property (@(posedge clk) disable iff (!rst_n) flush_pending |-> !field_valid)
		else $error("field issued during final flush");

endmodule

/* src/crc32_update.sv */
// Byte-serial gzip CRC32 that runs until reset, so one stream per reset
`timescale 1ns/10ps
`include "deflate_defs.svh"

module crc32_update (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 crc_valid,
	input  deflate_pkg::byte_t   crc_byte,
	output deflate_pkg::crc_t    crc_value
);

	import deflate_pkg::*;

	crc_t crc_q; // Running register, not yet inverted

	// ======================================================================
	// One byte folded in LSB first over eight shift steps
	// ======================================================================

	function automatic crc_t crc_step(input crc_t crc_in, input byte_t data);
		crc_t c;
		c = crc_in ^ {24'b0, data};
		for (int i = 0; i < 8; i++) begin
			if (c[0])
				c = (c >> 1) ^ `CRC32_POLY_REFLECTED;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	// The new value shows on crc_value one cycle after crc_valid
	always_ff @(posedge clk) begin
		if (!rst_n)
			crc_q <= `CRC32_INIT;
		else if (crc_valid)
			crc_q <= crc_step(crc_q, crc_byte);
	end

	// Final inversion makes this the gzip CRC of every byte taken so far
	// With no bytes at all this gives 00000000
	assign crc_value = ~crc_q;

endmodule

/* src/sync_fifo.sv */
// Fall-through FIFO where dout is valid while empty is low, and a push while full is dropped
`timescale 1ns/10ps

module sync_fifo #(
	parameter int width     = 32, // Bits per entry
	parameter int depth_log = 4   // Entries as log2
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               push,
	input  logic [width-1:0]   din,
	input  logic               pop,
	output logic [width-1:0]   dout,
	output logic               full,
	output logic               empty,
	output logic [depth_log:0] level // Number of entries held
);

	localparam int depth = 1 << depth_log;

	logic [width-1:0]     mem [depth];
	logic [depth_log-1:0] wr_ptr;
	logic [depth_log-1:0] rd_ptr;
	logic                 wr_en;
	logic                 rd_en;

	assign wr_en = push && !full;  // Writes into a full FIFO are lost
	assign rd_en = pop && !empty;

	// Storage array is cleared by reset and written at the write pointer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < depth; i++)
				mem[i] <= '0;
		end else if (wr_en)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1; // Pointers wrap at the depth
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level; // Both or neither leaves the count as is
			endcase
		end
	end

	// Head entry is visible without a read cycle
	assign dout  = mem[rd_ptr];
	assign full  = (level == (depth_log + 1)'(depth));
	assign empty = (level == '0);

	// Both sides of the FIFO are expected to respect the flags
	assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
		else $error("push into full FIFO");
	assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
		else $error("pop from empty FIFO");

endmodule

/* common/deflate_pkg.sv */
// Types only, with the word width taken from deflate_defs.svh on the include path
`include "deflate_defs.svh"

package deflate_pkg;

	// ======================================================================
	// Vector types with a meaning of their own
	// ======================================================================

	typedef logic [7:0]                   byte_t;      // One data byte
	typedef logic [`DEFLATE_WORD_W-1:0]   word_t;      // One bus word
	typedef logic [15:0]                  block_len_t; // LEN or NLEN of a stored block
	typedef logic [31:0]                  crc_t;       // CRC32 value

	// Number of bits in one packer field from 1 to 32
	typedef logic [5:0]                   bit_count_t;

	// ======================================================================
	// Stored block controller FSM
	// ======================================================================

	typedef enum logic [2:0] {
		st_idle,          // Waiting for an input word and output room
		st_block_header,  // BFINAL and BTYPE padded to one byte
		st_block_len,     // LEN and NLEN as one 32 bit field
		st_load_byte,     // One data byte per cycle
		st_end_of_block,  // Lets the CRC take in the last byte
		st_crc32,         // Trailer CRC32
		st_isize,         // Trailer ISIZE, closes the stream
		st_done           // Held until reset
	} ctrl_state_t;

endpackage

/* common/deflate_defs.svh */
// Bus width is fixed at 32 bits and both FIFO depths must be powers of two given as log2
`ifndef DEFLATE_DEFS_SVH
`define DEFLATE_DEFS_SVH

// ==========================================================================
// Bus and FIFO sizing
// ==========================================================================

`define DEFLATE_WORD_W        32 // Width of input and output bus words

`define IN_FIFO_DEPTH_LOG     5  // Input FIFO holds 32 words
`define OUT_FIFO_DEPTH_LOG    4  // Output FIFO holds 16 words

// Controller stops taking new input words at this output occupancy
// The gap to full covers packer words still in flight plus the trailer
`define OUT_ALMOST_FULL_LEVEL 12

// ==========================================================================
// Block header word layout and CRC32 constants
// ==========================================================================

`define HDR_BFINAL_BIT        24 // BFINAL flag above LEN in bits 15:0

// Reflected form of the gzip polynomial 04C11DB7
`define CRC32_POLY_REFLECTED  32'hEDB8_8320
`define CRC32_INIT            32'hFFFF_FFFF // Register preset before the first byte

`endif
